/* source/nlc_pkg.sv */
// Widths, counts and enum types shared by every block of the non-linearity corrector
`default_nettype none

package nlc_pkg;

	localparam int NUM_CH      = 16;
	localparam int NUM_COEFF   = 6;                  // Orders 0 to 5
	localparam int COEFF_IDX_W = $clog2(NUM_COEFF);
	localparam int ADC_W       = 21;
	localparam int DATA_W      = 32;
	localparam int FRAC_W      = 16;

	typedef logic signed [ADC_W-1:0]  sample_t;
	typedef logic signed [DATA_W-1:0] word_t;

	// Only load and keep are implemented, the fitting modes act as keep
	typedef enum logic [1:0] {
		MODE_LOAD_COEFF  = 2'b00,
		MODE_FIT_UPGRADE = 2'b01,
		MODE_FIT_ERROR   = 2'b10,
		MODE_USE_STORED  = 2'b11
	} op_mode_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_NORMALIZE,
		ST_HORNER,
		ST_RELEASE
	} nlc_state_e;

endpackage

`default_nettype wire

/* source/mac_if.sv */
// Issue and result paths of the shared add-multiply-add unit, connect sequencer, unit and buffer
`default_nettype none

interface mac_if import nlc_pkg::*; #(
	parameter int N_CH = NUM_CH
);

	localparam int CH_W = $clog2(N_CH);

	// Issue group
	logic            op_valid;
	logic [CH_W-1:0] op_ch;
	word_t           op_a;
	word_t           op_b;
	word_t           op_m;
	word_t           op_c;

	// Result group
	logic            res_valid;
	logic [CH_W-1:0] res_ch;
	word_t           res_value;

	modport issuer (
		output op_valid, op_ch, op_a, op_b, op_m, op_c,
		input  res_valid
	);

	modport unit (
		input  op_valid, op_ch, op_a, op_b, op_m, op_c,
		output res_valid, res_ch, res_value
	);

	modport sink (
		input res_valid, res_ch, res_value
	);

endinterface

`default_nettype wire

/* source/fixed_mul_add.sv */
// Three-stage fixed-point ((a + b) * m >>> FRAC_W) + c unit, one operation accepted per cycle
`default_nettype none

module fixed_mul_add import nlc_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	mac_if.unit      mac
);

	localparam int CH_W = $bits(mac.op_ch);

	logic                       v1_q;
	logic                       v2_q;
	logic                       v3_q;
	logic [CH_W-1:0]            ch1_q;
	logic [CH_W-1:0]            ch2_q;
	logic [CH_W-1:0]            ch3_q;
	word_t                      sum1_q;
	word_t                      m1_q;
	word_t                      c1_q;
	logic signed [2*DATA_W-1:0] prod2_q;
	word_t                      c2_q;
	word_t                      res_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			v1_q <= 1'b0;
			v2_q <= 1'b0;
			v3_q <= 1'b0;
		end else begin
			v1_q <= mac.op_valid;
			v2_q <= v1_q;
			v3_q <= v2_q;
		end
	end

	always_ff @(posedge clk) begin
		// Stage 1
		ch1_q  <= mac.op_ch;
		sum1_q <= mac.op_a + mac.op_b;   // Wraps at 32 bits
		m1_q   <= mac.op_m;
		c1_q   <= mac.op_c;
		// Stage 2, full 64-bit product
		ch2_q   <= ch1_q;
		prod2_q <= sum1_q * m1_q;
		c2_q    <= c1_q;
		// Stage 3
		ch3_q <= ch2_q;
		res_q <= word_t'(prod2_q >>> FRAC_W) + c2_q;
	end

	assign mac.res_valid = v3_q;
	assign mac.res_ch    = ch3_q;
	assign mac.res_value = res_q;

	// Every operation comes back with its own channel tag, three cycles later
	a_latency: assert property (@(posedge clk) disable iff (reset)
		mac.op_valid |-> ##3 (mac.res_valid && mac.res_ch == $past(mac.op_ch, 3)));

	a_no_spurious: assert property (@(posedge clk) disable iff (reset)
		mac.res_valid |-> $past(mac.op_valid, 3));

endmodule

`default_nettype wire

/* source/nlc_param_store.sv */
// Per-channel mean, deviation and coefficient registers, loaded on capture and read by channel
`default_nettype none

module nlc_param_store import nlc_pkg::*; #(
	parameter int N_CH = NUM_CH
) (
	input wire logic                               clk,
	input wire logic                               reset,
	input wire logic                               capture_i,
	input var  op_mode_e                           op_mode_i,
	input wire word_t [N_CH-1:0]                   neg_mean_i,
	input wire word_t [N_CH-1:0]                   recip_stdev_i,
	input wire word_t [N_CH-1:0][NUM_COEFF-1:0]    coeff_i,
	input wire logic [$clog2(N_CH)-1:0]            rd_ch_i,
	input wire logic [COEFF_IDX_W-1:0]             coeff_idx_i,
	output word_t                                  neg_mean_o,
	output word_t                                  recip_stdev_o,
	output word_t                                  coeff_o,
	output word_t                                  coeff5_o
);

	word_t [N_CH-1:0]                neg_mean_q;
	word_t [N_CH-1:0]                recip_stdev_q;
	word_t [N_CH-1:0][NUM_COEFF-1:0] coeff_q;

	always_ff @(posedge clk) begin
		if (capture_i) begin
			neg_mean_q    <= neg_mean_i;
			recip_stdev_q <= recip_stdev_i;
			// Other modes keep the last loaded set
			if (op_mode_i == MODE_LOAD_COEFF)
				coeff_q <= coeff_i;
		end
	end

	assign neg_mean_o    = neg_mean_q[rd_ch_i];
	assign recip_stdev_o = recip_stdev_q[rd_ch_i];
	assign coeff_o       = coeff_q[rd_ch_i][coeff_idx_i];
	assign coeff5_o      = coeff_q[rd_ch_i][NUM_COEFF-1];   // Horner seed

	// Sequencer only walks orders 4 down to 0
	a_coeff_idx: assert property (@(posedge clk) disable iff (reset)
		coeff_idx_i <= COEFF_IDX_W'(NUM_COEFF - 1));

endmodule

`default_nettype wire

/* source/nlc_sample_buffer.sv */
// Working banks for readings, normalized values and partial sums, plus the held corrected outputs
`default_nettype none

module nlc_sample_buffer import nlc_pkg::*; #(
	parameter int N_CH = NUM_CH
) (
	input wire logic                    clk,
	input wire logic                    reset,
	input wire logic                    capture_i,
	input wire logic                    release_i,
	input wire sample_t [N_CH-1:0]      x_adc_i,
	mac_if.sink                         mac,
	input wire logic                    pass_is_norm_i,
	input wire logic [$clog2(N_CH)-1:0] rd_ch_i,
	output sample_t                     sample_o,
	output word_t                       norm_o,
	output word_t                       acc_o,
	output sample_t [N_CH-1:0]          x_lin_o
);

	sample_t            sample_q [N_CH];
	word_t              norm_q [N_CH];
	word_t              acc_q [N_CH];
	sample_t [N_CH-1:0] x_lin_q;
	sample_t [N_CH-1:0] lin_next;

	always_ff @(posedge clk) begin
		if (capture_i) begin
			for (int i = 0; i < N_CH; i++)
				sample_q[i] <= x_adc_i[i];
		end
		if (mac.res_valid) begin
			if (pass_is_norm_i)
				norm_q[mac.res_ch] <= mac.res_value;
			else
				acc_q[mac.res_ch] <= mac.res_value;   // Partial sums overwrite in place
		end
	end

	always_comb begin
		for (int i = 0; i < N_CH; i++)
			lin_next[i] = sample_t'(acc_q[i] >>> FRAC_W);
	end

	always_ff @(posedge clk) begin
		if (reset)
			x_lin_q <= '0;
		else if (release_i)
			x_lin_q <= lin_next;
	end

	assign sample_o = sample_q[rd_ch_i];
	assign norm_o   = norm_q[rd_ch_i];
	assign acc_o    = acc_q[rd_ch_i];

	// New values show up together with the done pulse
	assign x_lin_o = release_i ? lin_next : x_lin_q;

endmodule

`default_nettype wire

/* source/nlc_sequencer.sv */
// Pass FSM of the corrector, issues one channel per cycle into the shared unit and counts results
`default_nettype none

module nlc_sequencer import nlc_pkg::*; #(
	parameter int N_CH = NUM_CH
) (
	input wire logic                    clk,
	input wire logic                    reset,
	input wire logic                    srdyi_i,
	output logic                        capture_o,
	output logic                        release_o,
	output logic                        pass_is_norm_o,
	mac_if.issuer                       mac,
	output logic [$clog2(N_CH)-1:0]     rd_ch_o,
	output logic [COEFF_IDX_W-1:0]      coeff_idx_o,
	input wire sample_t                 sample_i,
	input wire word_t                   norm_i,
	input wire word_t                   buf_word_i,
	input wire word_t                   neg_mean_i,
	input wire word_t                   recip_stdev_i,
	input wire word_t                   coeff_i,
	input wire word_t                   coeff5_i
);

	localparam int CH_W = $clog2(N_CH);

	nlc_state_e             state;
	logic                   issuing;
	logic [CH_W-1:0]        issue_cnt;
	logic [CH_W-1:0]        res_cnt;
	logic [COEFF_IDX_W-1:0] coeff_idx;
	logic                   pass_done;
	logic                   first_horner;

	assign pass_done    = mac.res_valid && (res_cnt == CH_W'(N_CH - 1));
	assign first_horner = (coeff_idx == COEFF_IDX_W'(NUM_COEFF - 2));

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			issuing   <= 1'b0;
			issue_cnt <= '0;
			res_cnt   <= '0;
			coeff_idx <= '0;
		end else begin
			if (issuing) begin
				issue_cnt <= issue_cnt + 1'b1;
				if (issue_cnt == CH_W'(N_CH - 1))
					issuing <= 1'b0;
			end
			if (mac.res_valid)
				res_cnt <= res_cnt + 1'b1;

			case (state)
				ST_IDLE: begin
					if (srdyi_i) begin
						state     <= ST_NORMALIZE;
						issuing   <= 1'b1;
						issue_cnt <= '0;
						res_cnt   <= '0;
						coeff_idx <= COEFF_IDX_W'(NUM_COEFF - 2);
					end
				end
				ST_NORMALIZE: begin
					if (pass_done) begin
						state   <= ST_HORNER;
						issuing <= 1'b1;
					end
				end
				ST_HORNER: begin
					if (pass_done) begin
						if (coeff_idx == '0) begin
							state <= ST_RELEASE;
						end else begin
							coeff_idx <= coeff_idx - 1'b1;
							issuing   <= 1'b1;
						end
					end
				end
				ST_RELEASE: state <= ST_IDLE;
				default:    state <= ST_IDLE;
			endcase
		end
	end

	assign capture_o      = (state == ST_IDLE) && srdyi_i;   // Strobes while busy fall through
	assign release_o      = (state == ST_RELEASE);
	assign pass_is_norm_o = (state == ST_NORMALIZE);

	assign rd_ch_o     = issue_cnt;
	assign coeff_idx_o = coeff_idx;

	assign mac.op_valid = issuing;
	assign mac.op_ch    = issue_cnt;

	always_comb begin
		if (state == ST_NORMALIZE) begin
			mac.op_a = word_t'(sample_i) <<< FRAC_W;
			mac.op_b = neg_mean_i;
			mac.op_m = recip_stdev_i;
			mac.op_c = '0;
		end else begin
			// Horner step, seeded with c5 on the first pass
			mac.op_a = first_horner ? coeff5_i : buf_word_i;
			mac.op_b = '0;
			mac.op_m = norm_i;
			mac.op_c = coeff_i;
		end
	end

	a_issue_state: assert property (@(posedge clk) disable iff (reset)
		mac.op_valid |-> (state inside {ST_NORMALIZE, ST_HORNER}));

endmodule

`default_nettype wire

/* source/nlc_top.sv */
// Top level of the multi-channel ADC non-linearity corrector, instantiate with the channel count
`default_nettype none

module nlc_top import nlc_pkg::*; #(
	parameter int N_CH = NUM_CH
) (
	input wire logic                            clk,
	input wire logic                            reset,
	input wire logic                            srdyi_i,
	input var  op_mode_e                        op_mode_i,
	input wire sample_t [N_CH-1:0]              x_adc_i,
	input wire word_t [N_CH-1:0]                neg_mean_i,
	input wire word_t [N_CH-1:0]                recip_stdev_i,
	input wire word_t [N_CH-1:0][NUM_COEFF-1:0] coeff_i,
	output sample_t [N_CH-1:0]                  x_lin_o,
	output logic                                srdyo_o
);

	localparam int CH_W = $clog2(N_CH);

	logic                   capture;
	logic                   rel_pulse;
	logic                   pass_is_norm;
	logic [CH_W-1:0]        rd_ch;
	logic [COEFF_IDX_W-1:0] coeff_idx;
	sample_t                sample_rd;
	word_t                  norm_rd;
	word_t                  acc_rd;
	word_t                  neg_mean_rd;
	word_t                  recip_stdev_rd;
	word_t                  coeff_rd;
	word_t                  coeff5_rd;

	mac_if #(.N_CH(N_CH)) mac ();

	nlc_sequencer #(.N_CH(N_CH)) i_sequencer (
		.clk            (clk),
		.reset          (reset),
		.srdyi_i        (srdyi_i),
		.capture_o      (capture),
		.release_o      (rel_pulse),
		.pass_is_norm_o (pass_is_norm),
		.mac            (mac.issuer),
		.rd_ch_o        (rd_ch),
		.coeff_idx_o    (coeff_idx),
		.sample_i       (sample_rd),
		.norm_i         (norm_rd),
		.buf_word_i     (acc_rd),
		.neg_mean_i     (neg_mean_rd),
		.recip_stdev_i  (recip_stdev_rd),
		.coeff_i        (coeff_rd),
		.coeff5_i       (coeff5_rd)
	);

	nlc_param_store #(.N_CH(N_CH)) i_param_store (
		.clk           (clk),
		.reset         (reset),
		.capture_i     (capture),
		.op_mode_i     (op_mode_i),
		.neg_mean_i    (neg_mean_i),
		.recip_stdev_i (recip_stdev_i),
		.coeff_i       (coeff_i),
		.rd_ch_i       (rd_ch),
		.coeff_idx_i   (coeff_idx),
		.neg_mean_o    (neg_mean_rd),
		.recip_stdev_o (recip_stdev_rd),
		.coeff_o       (coeff_rd),
		.coeff5_o      (coeff5_rd)
	);

	nlc_sample_buffer #(.N_CH(N_CH)) i_sample_buffer (
		.clk            (clk),
		.reset          (reset),
		.capture_i      (capture),
		.release_i      (rel_pulse),
		.x_adc_i        (x_adc_i),
		.mac            (mac.sink),
		.pass_is_norm_i (pass_is_norm),
		.rd_ch_i        (rd_ch),
		.sample_o       (sample_rd),
		.norm_o         (norm_rd),
		.acc_o          (acc_rd),
		.x_lin_o        (x_lin_o)
	);

	fixed_mul_add i_fixed_mul_add (
		.clk   (clk),
		.reset (reset),
		.mac   (mac.unit)
	);

	assign srdyo_o = rel_pulse;

endmodule

`default_nettype wire

/* sim/nlc_tb.sv */
// Self-checking testbench for nlc_top, runs the vectors of sim/nlc_input.txt from the project root
`default_nettype none

module nlc_tb import nlc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_CH         = 16;
	localparam int NUM_VEC      = 3;
	localparam int ROW_W        = 10;              // Words per channel line
	localparam int VEC_STRIDE   = 1 + N_CH * ROW_W;
	localparam int VEC_WORDS    = NUM_VEC * VEC_STRIDE;
	localparam int DONE_TIMEOUT = 2000;

	logic                             clk = 1'b0;
	logic                             reset;
	logic                             srdyi_i;
	op_mode_e                         op_mode_i;
	sample_t [N_CH-1:0]               x_adc_i;
	word_t [N_CH-1:0]                 neg_mean_i;
	word_t [N_CH-1:0]                 recip_stdev_i;
	word_t [N_CH-1:0][NUM_COEFF-1:0]  coeff_i;
	sample_t [N_CH-1:0]               x_lin_o;
	logic                             srdyo_o;

	logic [31:0]        vec_mem [0:VEC_WORDS-1];
	int                 errors;
	int                 checks;
	int                 done_count;
	int                 seed = 85487;
	logic               timed_out;
	logic               mon_en;
	logic               done_prev;
	sample_t [N_CH-1:0] held;

	nlc_top #(.N_CH(N_CH)) i_dut (
		.clk           (clk),
		.reset         (reset),
		.srdyi_i       (srdyi_i),
		.op_mode_i     (op_mode_i),
		.x_adc_i       (x_adc_i),
		.neg_mean_i    (neg_mean_i),
		.recip_stdev_i (recip_stdev_i),
		.coeff_i       (coeff_i),
		.x_lin_o       (x_lin_o),
		.srdyo_o       (srdyo_o)
	);

	always #50 clk = ~clk;

	// Outputs may only move together with the done pulse, and the pulse lasts one cycle
	always @(negedge clk) begin
		if (mon_en) begin
			if (srdyo_o && done_prev) begin
				errors++;
				$display("srdyo_o stayed high for two consecutive cycles");
			end
			if (!srdyo_o && x_lin_o !== held) begin
				errors++;
				$display("x_lin_o changed between done pulses");
			end
			if (srdyo_o)
				done_count++;
			held      = x_lin_o;
			done_prev = srdyo_o;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_done(output logic seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < DONE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (srdyo_o === 1'b1)
				seen = 1'b1;
		end
		if (!seen) begin
			errors++;
			$display("Timeout: the srdyo_o done pulse never came within %0d cycles", DONE_TIMEOUT);
		end
	endtask

	// Applies one vector, optionally strobes again while busy, then checks the released outputs
	task automatic run_vector(input int v, input logic busy_strobe);
		int                 base;
		int                 row;
		int                 count_before;
		logic               seen;
		logic [31:0]        rnd;
		logic [ADC_W-1:0]   expected [N_CH];
		base = v * VEC_STRIDE;
		@(posedge clk);
		op_mode_i <= op_mode_e'(vec_mem[base][1:0]);
		for (int ch = 0; ch < N_CH; ch++) begin
			row = base + 1 + ch * ROW_W;
			x_adc_i[ch]       <= vec_mem[row][ADC_W-1:0];
			neg_mean_i[ch]    <= vec_mem[row + 1];
			recip_stdev_i[ch] <= vec_mem[row + 2];
			for (int k = 0; k < NUM_COEFF; k++)
				coeff_i[ch][k] <= vec_mem[row + 3 + k];
			expected[ch] = vec_mem[row + 9][ADC_W-1:0];
		end
		srdyi_i <= 1'b1;
		count_before = done_count;
		@(posedge clk);
		srdyi_i <= 1'b0;
		if (busy_strobe) begin
			wait_cycles(5);
			for (int ch = 0; ch < N_CH; ch++) begin
				rnd = $random(seed);
				x_adc_i[ch] <= rnd[ADC_W-1:0];
			end
			srdyi_i <= 1'b1;   // Lands mid-normalize pass
			@(posedge clk);
			srdyi_i <= 1'b0;
		end
		wait_done(seen);
		if (!seen) begin
			timed_out = 1'b1;
		end else begin
			for (int ch = 0; ch < N_CH; ch++) begin
				checks++;
				if (x_lin_o[ch] !== expected[ch]) begin
					errors++;
					$display("FAIL x_lin_o[%0d] expected %h got %h", ch, expected[ch], x_lin_o[ch]);
				end
			end
			if (busy_strobe) begin
				wait_cycles(150);
				checks++;
				if (done_count != count_before + 1) begin
					errors++;
					$display("Expected exactly one done pulse after the busy strobe, saw %0d",
						done_count - count_before);
				end
			end
		end
	endtask

	initial begin
		reset         = 1'b1;
		srdyi_i       = 1'b0;
		op_mode_i     = MODE_USE_STORED;
		x_adc_i       = '0;
		neg_mean_i    = '0;
		recip_stdev_i = '0;
		coeff_i       = '0;
		errors        = 0;
		checks        = 0;
		done_count    = 0;
		timed_out     = 1'b0;
		mon_en        = 1'b0;
		done_prev     = 1'b0;
		held          = '0;

		$readmemh("sim/nlc_input.txt", vec_mem);
		if ($isunknown(vec_mem[VEC_WORDS-1])) begin
			errors++;
			timed_out = 1'b1;   // Nothing to run without vectors
			$display("Data file sim/nlc_input.txt is missing or incomplete");
		end

		wait_cycles(3);
		reset <= 1'b0;
		@(negedge clk);
		checks++;
		if (srdyo_o !== 1'b0) begin
			errors++;
			$display("FAIL srdyo_o expected %h got %h", 1'b0, srdyo_o);
		end
		for (int ch = 0; ch < N_CH; ch++) begin
			if (x_lin_o[ch] !== '0) begin
				errors++;
				$display("FAIL x_lin_o[%0d] expected %h got %h", ch, sample_t'(0), x_lin_o[ch]);
			end
		end
		held   = x_lin_o;
		mon_en = 1'b1;

		if (!timed_out)
			run_vector(0, 1'b0);   // Load coefficients
		if (!timed_out)
			run_vector(1, 1'b0);   // Keep stored coefficients
		if (!timed_out)
			run_vector(2, 1'b1);   // Fitting mode acts as stored, extra strobe while busy

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
source/nlc_pkg.sv
source/mac_if.sv
source/fixed_mul_add.sv
source/nlc_param_store.sv
source/nlc_sample_buffer.sv
source/nlc_sequencer.sv
source/nlc_top.sv
sim/nlc_tb.sv

/* sim/nlc_input.txt */
// Per vector one op mode line, then 16 channel lines of hex words:
// reading neg_mean recip_stdev c0 c1 c2 c3 c4 c5 expected_x_lin
00 // Vector 1, load coefficients
000100 ff030000 00010000 00000000 00010000 00000000 00000000 00000000 00000000 000003
000800 f8000000 00010000 00050000 00000000 00000000 00000000 00000000 00000000 000005
000010 ffed0000 00010000 00000000 00000000 00010000 00000000 00000000 00000000 000009
000400 fc020000 00010000 00010000 00010000 00010000 00010000 00010000 00010000 00003f
000200 fdff0000 00020000 00000000 00000000 00000000 00000000 00000000 00010000 1fffe0
001000 f0040000 00008000 fffd0000 00020000 00000000 00000000 00000000 00000000 000001
000050 ffb20000 00010000 00008000 00010000 00000000 00000000 00000000 00000000 000002
000300 fd020000 00010000 000a0000 ffff0000 00000000 00010000 00000000 00000000 000010
1fff00 01030000 00010000 00000000 00000000 00000000 00010000 00000000 00000000 00001b
000020 ffdf0000 00010000 00020000 fffe0000 00010000 00000000 00000000 00000000 000005
000700 f9010000 00020000 ffff0000 00000000 00000000 00000000 00000000 ffff0000 1fffdf
000060 ff9e0000 00008000 00000000 00030000 00000000 00000000 ffff0000 00000000 1ffffc
000abc f5470000 00010000 00010000 00000000 00020000 00000000 00000000 00000000 000013
000100 fefc0000 00010000 ffff8000 00010000 00000000 00000000 00000000 00000000 1ffffb
000040 ffbe0000 00010000 00070000 00000000 00000000 00000000 00010000 00000000 000017
000500 fb020000 00010000 00000000 ffff0000 00000000 00000000 00000000 00010000 00001e
03 // Vector 2, keep stored coefficients
000010 ffeb0000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 1ffffb
000107 ff000000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000005
000204 fe000000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000010
000300 fcff0000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000000
000006 00000000 00008000 00090000 00080000 00070000 00060000 00050000 00040000 0000f3
000000 fffe0000 00020000 00090000 00080000 00070000 00060000 00050000 00040000 1ffff5
1ffff0 000d0000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 1ffffd
000100 fefe0000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000004
000400 fbff0000 00020000 00090000 00080000 00070000 00060000 00050000 00040000 1ffff8
000033 ffd00000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000005
000080 ff7f0000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000000
000208 fdfc0000 00008000 00090000 00080000 00070000 00060000 00050000 00040000 1ffff6
000001 fffc0000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000013
000105 ff000000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000004
000903 f7000000 00010000 00090000 00080000 00070000 00060000 00050000 00040000 000058
000010 ffef0000 00020000 00090000 00080000 00070000 00060000 00050000 00040000 1fffe2
02 // Vector 3, error fitting mode keeps stored coefficients
000002 ffff0000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000001
000000 fffd0000 00020000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000005
001234 edcb0000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000001
000010 fff10000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000006
000002 00000000 00008000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000001
000777 f8890000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 1ffffd
000020 ffdf0000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 1fffff
000003 00000000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000022
1ffffd 00000000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 1fffe5
000100 ff000000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000002
000050 ffaf0000 00020000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 00001f
000044 ffbe0000 00008000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000002
000009 fff60000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000003
000300 fd000000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 1fffff
000111 feee0000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000008
000222 fddd0000 00010000 00030000 fffd0000 00030000 fffd0000 00030000 fffd0000 000000
